//--- Bender.yml
package:
  name: rv_core

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/rv_pkg.sv
      - design/rv_decode_if.sv
      - design/rv_decoder.sv
      - design/rv_regfile.sv
      - design/rv_alu.sv
      - design/rv_lsu.sv
      - design/rv_core.sv
  - target: simulation
    include_dirs:
      - design
      - verif
    files:
      - verif/rv_core_tb.sv

//--- design/rv_alu.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_alu import rv_pkg::*; (
  rv_decode_if.consumer       dec,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  input  logic [`RV_XLEN-1:0] pc,
  output logic [`RV_XLEN-1:0] result,
  output logic                branch_taken
);
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [4:0]          shamt;

  assign op_a  = (dec.wb_sel == WB_PC_IMM) ? pc : rs1_data; // AUIPC adds to pc
  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_SLL:    result = op_a << shamt;
      ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   result = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SRL:    result = op_a >> shamt;
      ALU_SRA:    result = $signed(op_a) >>> shamt;
      ALU_OR:     result = op_a | op_b;
      ALU_AND:    result = op_a & op_b;
      ALU_PASS_B: result = op_b;
      default:    result = op_a + op_b;
    endcase
  end

  // Branches always compare the two registers
  always_comb begin
    case (dec.br_cond)
      BR_EQ:   branch_taken = (rs1_data == rs2_data);
      BR_NE:   branch_taken = (rs1_data != rs2_data);
      BR_LT:   branch_taken = $signed(rs1_data) < $signed(rs2_data);
      BR_GE:   branch_taken = $signed(rs1_data) >= $signed(rs2_data);
      BR_LTU:  branch_taken = rs1_data < rs2_data;
      BR_GEU:  branch_taken = rs1_data >= rs2_data;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

//--- design/rv_core.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core import rv_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  output logic [`RV_XLEN-1:0]    imem_addr,
  input  logic [`RV_XLEN-1:0]    imem_rdata,
  output logic [`RV_XLEN-1:0]    dmem_addr,
  input  logic [`RV_XLEN-1:0]    dmem_rdata,
  output logic [`RV_XLEN-1:0]    dmem_wdata,
  output logic [`RV_XLEN/8-1:0]  dmem_be,
  output logic                   halt
);
  logic [`RV_XLEN-1:0]   pc;
  logic [`RV_XLEN-1:0]   pc_next;
  logic [`RV_XLEN-1:0]   pc_step;
  logic [`RV_XLEN-1:0]   pc_imm;     // Branch and JAL target
  logic [`RV_XLEN-1:0]   rs1_data, rs2_data;
  logic [`RV_XLEN-1:0]   alu_result;
  logic [`RV_XLEN-1:0]   load_data;
  logic [`RV_XLEN-1:0]   rd_data;
  logic [`RV_XLEN/8-1:0] lsu_be;
  logic                  branch_taken;

  rv_decode_if dec ();

  rv_decoder u_decoder (.insn(imem_rdata), .dec(dec));

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1_idx  (dec.rs1),
    .rs2_idx  (dec.rs2),
    .rd_idx   (dec.rd),
    .rd_data  (rd_data),
    .we       (dec.rf_we),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu u_alu (
    .dec          (dec),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .pc           (pc),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  // Load/store address is rs1 + imm from the ALU
  rv_lsu u_lsu (
    .dec        (dec),
    .eff_addr   (alu_result),
    .rs2_data   (rs2_data),
    .dmem_rdata (dmem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_be    (lsu_be),
    .load_data  (load_data)
  );

  assign pc_step = pc + `RV_PC_STEP;
  assign pc_imm  = pc + dec.imm;

  always_comb begin
    if (dec.is_jalr) pc_next = {alu_result[`RV_XLEN-1:1], 1'b0};
    else if (dec.is_jal || branch_taken) pc_next = pc_imm;
    else pc_next = pc_step;
  end

  always_ff @(posedge clk) begin
    if (rst) pc <= `RV_RESET_PC;
    else     pc <= pc_next;
  end

  always_comb begin
    case (dec.wb_sel)
      WB_LOAD:    rd_data = load_data;
      WB_PC_STEP: rd_data = pc_step;    // JAL/JALR link
      default:    rd_data = alu_result; // ALU ops and AUIPC
    endcase
  end

  assign imem_addr = pc;
  assign dmem_be   = rst ? '0 : lsu_be; // No stray stores while in reset
  assign halt      = rst ? 1'b0 : dec.halt_req;

  // JALR clears bit 0 only, so targets rely on aligned offsets
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) imem_addr[1:0] == 2'b00)
    else $error("imem_addr %h not word aligned", imem_addr);

endmodule

//--- design/rv_decode_if.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

interface rv_decode_if import rv_pkg::*; ();
  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  logic [`RV_REG_AW-1:0] rd;
  logic [`RV_XLEN-1:0]   imm;     // Already sign extended
  alu_op_e               alu_op;
  logic                  use_imm; // Operand B from imm instead of rs2
  br_cond_e              br_cond;
  ld_kind_e              ld_kind;
  st_kind_e              st_kind;
  wb_sel_e               wb_sel;
  logic                  rf_we;   // Never set for rd == x0
  logic                  is_jal;
  logic                  is_jalr;
  logic                  halt_req;

  modport decoder (
    output rs1, rs2, rd, imm, alu_op, use_imm, br_cond, ld_kind, st_kind,
           wb_sel, rf_we, is_jal, is_jalr, halt_req
  );

  modport consumer (
    input rs1, rs2, rd, imm, alu_op, use_imm, br_cond, ld_kind, st_kind,
          wb_sel, rf_we, is_jal, is_jalr, halt_req
  );
endinterface

//--- design/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_decoder import rv_pkg::*; (
  input  logic [`RV_XLEN-1:0] insn,
  rv_decode_if.decoder        dec
);
  opcode_e              opcode;
  logic [2:0]           funct3;
  logic                 alt_op; // SUB or SRA/SRAI
  logic                 wr_req; // Instruction writes rd, before the x0 check
  logic [`RV_XLEN-1:0]  imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign alt_op = insn[30] && (funct3 == 3'b101 || (opcode == OP_REG && funct3 == 3'b000));

  assign dec.rs1 = insn[19:15];
  assign dec.rs2 = insn[24:20];
  assign dec.rd  = insn[11:7];

  // Immediate formats
  assign imm_i = {{(`RV_XLEN-12){insn[31]}}, insn[31:20]};
  assign imm_s = {{(`RV_XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{(`RV_XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    // Defaults give a no-op
    wr_req       = 1'b0;
    dec.imm      = imm_i;
    dec.alu_op   = ALU_ADD;
    dec.use_imm  = 1'b0;
    dec.br_cond  = BR_NONE;
    dec.ld_kind  = LD_NONE;
    dec.st_kind  = ST_NONE;
    dec.wb_sel   = WB_ALU;
    dec.is_jal   = 1'b0;
    dec.is_jalr  = 1'b0;
    dec.halt_req = 1'b0;

    case (opcode)
      OP_LUI: begin
        wr_req      = 1'b1;
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
        dec.alu_op  = ALU_PASS_B;
      end
      OP_AUIPC: begin
        wr_req      = 1'b1;
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
        dec.wb_sel  = WB_PC_IMM; // ALU takes pc as operand A
      end
      OP_IMM: begin
        wr_req      = 1'b1;
        dec.use_imm = 1'b1;
        dec.alu_op  = alu_op_e'({alt_op, funct3});
      end
      OP_REG: begin
        wr_req     = 1'b1;
        dec.alu_op = alu_op_e'({alt_op, funct3});
      end
      OP_BRANCH: begin
        dec.imm = imm_b;
        case (funct3)
          3'b000:  dec.br_cond = BR_EQ;
          3'b001:  dec.br_cond = BR_NE;
          3'b100:  dec.br_cond = BR_LT;
          3'b101:  dec.br_cond = BR_GE;
          3'b110:  dec.br_cond = BR_LTU;
          3'b111:  dec.br_cond = BR_GEU;
          default: dec.br_cond = BR_NONE;
        endcase
      end
      OP_JAL: begin
        wr_req     = 1'b1;
        dec.imm    = imm_j;
        dec.wb_sel = WB_PC_STEP; // Link address
        dec.is_jal = 1'b1;
      end
      OP_JALR: begin
        wr_req      = 1'b1;
        dec.use_imm = 1'b1;
        dec.wb_sel  = WB_PC_STEP;
        dec.is_jalr = 1'b1;
      end
      OP_LOAD: begin
        dec.use_imm = 1'b1;
        dec.wb_sel  = WB_LOAD;
        wr_req      = 1'b1;
        case (funct3)
          3'b000:  dec.ld_kind = LD_B;
          3'b001:  dec.ld_kind = LD_H;
          3'b010:  dec.ld_kind = LD_W;
          3'b100:  dec.ld_kind = LD_BU;
          3'b101:  dec.ld_kind = LD_HU;
          default: wr_req = 1'b0; // Undefined width, no-op
        endcase
      end
      OP_STORE: begin
        dec.imm     = imm_s;
        dec.use_imm = 1'b1;
        case (funct3)
          3'b000:  dec.st_kind = ST_B;
          3'b001:  dec.st_kind = ST_H;
          3'b010:  dec.st_kind = ST_W;
          default: dec.st_kind = ST_NONE;
        endcase
      end
      OP_SYSTEM: dec.halt_req = (insn[31:7] == '0); // ECALL only
      default: ; // FENCE and unknown opcodes fall through as no-ops
    endcase
  end

  // Writes to x0 are dropped here, so the register file never sees them
  assign dec.rf_we = wr_req && (dec.rd != '0);

endmodule

//--- design/rv_lsu.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_lsu import rv_pkg::*; (
  rv_decode_if.consumer             dec,
  input  logic [`RV_XLEN-1:0]       eff_addr,
  input  logic [`RV_XLEN-1:0]       rs2_data,
  input  logic [`RV_XLEN-1:0]       dmem_rdata,
  output logic [`RV_XLEN-1:0]       dmem_addr,
  output logic [`RV_XLEN-1:0]       dmem_wdata,
  output logic [`RV_XLEN/8-1:0]     dmem_be,
  output logic [`RV_XLEN-1:0]       load_data
);
  logic [1:0]          offset;
  logic [`RV_XLEN-1:0] lane;      // Addressed byte/half moved to bit 0
  logic                half_acc;
  logic                word_acc;

  assign offset    = eff_addr[1:0];
  assign dmem_addr = {eff_addr[`RV_XLEN-1:2], 2'b00};

  // Store path
  always_comb begin
    case (dec.st_kind)
      ST_B: begin
        dmem_wdata = {4{rs2_data[7:0]}};
        dmem_be    = 4'b0001 << offset;
      end
      ST_H: begin
        dmem_wdata = {2{rs2_data[15:0]}};
        dmem_be    = 4'b0011 << {offset[1], 1'b0};
      end
      ST_W: begin
        dmem_wdata = rs2_data;
        dmem_be    = 4'b1111;
      end
      default: begin
        dmem_wdata = rs2_data;
        dmem_be    = '0;
      end
    endcase
  end

  // Load path
  assign lane = dmem_rdata >> {offset, 3'b000};

  always_comb begin
    case (dec.ld_kind)
      LD_B:    load_data = {{(`RV_XLEN-8){lane[7]}}, lane[7:0]};
      LD_BU:   load_data = {{(`RV_XLEN-8){1'b0}}, lane[7:0]};
      LD_H:    load_data = {{(`RV_XLEN-16){lane[15]}}, lane[15:0]};
      LD_HU:   load_data = {{(`RV_XLEN-16){1'b0}}, lane[15:0]};
      default: load_data = dmem_rdata; // LW
    endcase
  end

  assign half_acc = (dec.ld_kind inside {LD_H, LD_HU}) || dec.st_kind == ST_H;
  assign word_acc = dec.ld_kind == LD_W || dec.st_kind == ST_W;

  // Misaligned accesses are not split across words
  always_comb begin
    a_half_align: assert final (!(half_acc && offset[0]))
      else $error("misaligned halfword access at %h", eff_addr);
    a_word_align: assert final (!(word_acc && offset != 2'b00))
      else $error("misaligned word access at %h", eff_addr);
  end

endmodule

//--- design/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Data path and address width
`define RV_XLEN 32

// Register index width and architectural register count
`define RV_REG_AW 5
`define RV_NUM_REGS 32

// Sequential fetch increment in bytes
`define RV_PC_STEP 4

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

`endif

//--- design/rv_pkg.sv
package rv_pkg;

  // Major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b000_0011,
    OP_MISC_MEM = 7'b000_1111, // FENCE
    OP_IMM      = 7'b001_0011,
    OP_AUIPC    = 7'b001_0111,
    OP_STORE    = 7'b010_0011,
    OP_REG      = 7'b011_0011,
    OP_LUI      = 7'b011_0111,
    OP_BRANCH   = 7'b110_0011,
    OP_JALR     = 7'b110_0111,
    OP_JAL      = 7'b110_1111,
    OP_SYSTEM   = 7'b111_0011
  } opcode_e;

  // Low three bits follow funct3, top bit is insn[30]
  typedef enum logic [3:0] {
    ALU_ADD    = 4'b0000,
    ALU_SLL    = 4'b0001,
    ALU_SLT    = 4'b0010,
    ALU_SLTU   = 4'b0011,
    ALU_XOR    = 4'b0100,
    ALU_SRL    = 4'b0101,
    ALU_OR     = 4'b0110,
    ALU_AND    = 4'b0111,
    ALU_SUB    = 4'b1000,
    ALU_SRA    = 4'b1101,
    ALU_PASS_B = 4'b1111  // LUI
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
  } br_cond_e;

  typedef enum logic [2:0] {
    LD_NONE, LD_B, LD_H, LD_W, LD_BU, LD_HU
  } ld_kind_e;

  typedef enum logic [1:0] {
    ST_NONE, ST_B, ST_H, ST_W
  } st_kind_e;

  // Writeback source
  typedef enum logic [1:0] {
    WB_ALU, WB_LOAD, WB_PC_STEP, WB_PC_IMM
  } wb_sel_e;

endpackage

//--- design/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`RV_REG_AW-1:0] rs1_idx,
  input  logic [`RV_REG_AW-1:0] rs2_idx,
  input  logic [`RV_REG_AW-1:0] rd_idx,
  input  logic [`RV_XLEN-1:0]   rd_data,
  input  logic                  we,
  output logic [`RV_XLEN-1:0]   rs1_data,
  output logic [`RV_XLEN-1:0]   rs2_data
);
  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_idx != '0) begin
      regs[rd_idx] <= rd_data;
    end
  end

  assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

  // Decoder masks x0 destinations before they reach the write port
  a_no_x0_write: assert property (@(posedge clk) disable iff (rst) !(we && rd_idx == '0))
    else $error("register file write request to x0");

endmodule

//--- rv_core.f
+incdir+design
+incdir+verif
design/rv_pkg.sv
design/rv_decode_if.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_lsu.sv
design/rv_core.sv
verif/rv_core_tb.sv

//--- verif/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Full-period 32-bit LCG
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// Integer ops selected by funct3, alt picks SUB or SRA
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0: if (alt) return a - b; else return a + b;
    3'd1: return a << b[4:0];
    3'd2: return {31'b0, $signed(a) < $signed(b)};
    3'd3: return {31'b0, a < b};
    3'd4: return a ^ b;
    3'd5: if (alt) return $signed(a) >>> b[4:0]; else return a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// Executes one instruction on the testbench copy of the architectural state
function automatic void ref_step(input logic [31:0] insn);
  logic [31:0] a, b, imm, res, addr, word, npc;
  logic [4:0]  rd;
  logic [2:0]  f3;
  logic        wr;
  logic        take;
  a         = ref_regs[insn[19:15]];
  b         = ref_regs[insn[24:20]];
  rd        = insn[11:7];
  f3        = insn[14:12];
  imm       = {{20{insn[31]}}, insn[31:20]}; // I format unless replaced
  npc       = ref_pc + `RV_PC_STEP;
  res       = '0;
  wr        = 1'b0;
  take      = 1'b0;
  exp_be    = '0;
  exp_addr  = '0;
  exp_wdata = '0;
  exp_halt  = 1'b0;
  case (insn[6:0])
    OP_LUI: begin
      wr  = 1'b1;
      res = {insn[31:12], 12'h000};
    end
    OP_AUIPC: begin
      wr  = 1'b1;
      res = ref_pc + {insn[31:12], 12'h000};
    end
    OP_IMM: begin
      wr  = 1'b1;
      res = alu_ref(f3, insn[30] && f3 == 3'd5, a, imm);
    end
    OP_REG: begin
      wr  = 1'b1;
      res = alu_ref(f3, insn[30], a, b);
    end
    OP_BRANCH: begin
      case (f3)
        3'd0:    take = (a == b);
        3'd1:    take = (a != b);
        3'd4:    take = $signed(a) < $signed(b);
        3'd5:    take = $signed(a) >= $signed(b);
        3'd6:    take = a < b;
        3'd7:    take = a >= b;
        default: take = 1'b0;
      endcase
      if (take) npc = ref_pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    end
    OP_JAL: begin
      wr  = 1'b1;
      res = ref_pc + `RV_PC_STEP;
      npc = ref_pc + {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    end
    OP_JALR: begin
      wr  = 1'b1;
      res = ref_pc + `RV_PC_STEP;
      npc = (a + imm) & 32'hffff_fffe;
    end
    OP_LOAD: begin
      addr = a + imm;
      word = ref_dmem[addr[9:2]] >> (8 * addr[1:0]);
      wr   = 1'b1;
      case (f3)
        3'd0:    res = {{24{word[7]}}, word[7:0]};
        3'd1:    res = {{16{word[15]}}, word[15:0]};
        3'd4:    res = {24'h0, word[7:0]};
        3'd5:    res = {16'h0, word[15:0]};
        default: res = word;
      endcase
    end
    OP_STORE: begin
      addr     = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
      exp_addr = addr & 32'hffff_fffc;
      case (f3)
        3'd0: begin
          exp_be    = 4'b0001 << addr[1:0];
          exp_wdata = {4{b[7:0]}};
        end
        3'd1: begin
          exp_be    = 4'b0011 << addr[1:0];
          exp_wdata = {2{b[15:0]}};
        end
        default: begin
          exp_be    = 4'b1111;
          exp_wdata = b;
        end
      endcase
      for (int i = 0; i < 4; i++) begin
        if (exp_be[i]) ref_dmem[addr[9:2]][8*i +: 8] = exp_wdata[8*i +: 8];
      end
    end
    OP_SYSTEM: exp_halt = (insn[31:7] == '0);
    default: ; // FENCE changes nothing
  endcase
  if (wr && rd != 5'd0) ref_regs[rd] = res;
  ref_pc = npc;
endfunction

`endif

//--- verif/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core_tb import rv_pkg::*; ();
  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 10;
  localparam int IMEM_WORDS = 512;
  localparam int DMEM_WORDS = 256;

  logic                  clk;
  logic                  rst;
  logic [`RV_XLEN-1:0]   imem_addr, imem_rdata;
  logic [`RV_XLEN-1:0]   dmem_addr, dmem_rdata, dmem_wdata;
  logic [`RV_XLEN/8-1:0] dmem_be;
  logic                  halt;

  logic [31:0] imem [0:IMEM_WORDS-1];
  logic [31:0] dmem [0:DMEM_WORDS-1];
  logic [31:0] prog [$];
  logic [31:0] seed = 32'h3a93;
  logic [31:0] st_ptr = 32'h100; // Next result slot
  int          prog_len = 0;

  // Model state
  logic [31:0] ref_pc;
  logic [31:0] ref_regs [0:`RV_NUM_REGS-1];
  logic [31:0] ref_dmem [0:DMEM_WORDS-1];
  logic [3:0]  exp_be;
  logic [31:0] exp_addr, exp_wdata;
  logic        exp_halt;
  logic        done;

  `include "rv_ref_model.svh"

  rv_core uut (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_rdata (dmem_rdata),
    .dmem_wdata (dmem_wdata),
    .dmem_be    (dmem_be),
    .halt       (halt)
  );

  // Combinational reads, byte writes at the rising edge
  assign imem_rdata = imem[imem_addr[10:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (dmem_be[i]) dmem[dmem_addr[9:2]][8*i +: 8] <= dmem_wdata[8*i +: 8];
    end
  end

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    seed = lcg_next(seed);
    return seed;
  endfunction

  function automatic logic [31:0] data_fill(input logic [31:0] addr);
    return addr * 32'h9e37_79b9 ^ 32'h5bd1_e995;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  // LUI + ADDI, upper part rounded for the sign-extended low part
  task automatic set_reg(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] hi;
    hi = value + 32'h800;
    prog.push_back(u_type(hi[31:12], rd, OP_LUI));
    prog.push_back(i_type(value[11:0], rd, 3'd0, rd, OP_IMM));
  endtask

  task automatic store_result(input logic [4:0] rs);
    prog.push_back(s_type(st_ptr[11:0], rs, 5'd0, 3'd2));
    st_ptr = st_ptr + 4;
  endtask

  task automatic build_program();
    logic [31:0] rv;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [2:0]  kinds [5];
    kinds = '{3'd0, 3'd4, 3'd1, 3'd5, 3'd2}; // LB LBU LH LHU LW
    for (int r = 0; r < 3; r++) begin
      set_reg(1, next_rand());
      set_reg(2, next_rand());
      for (int k = 0; k < 10; k++) begin
        f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5); // Last two are SUB, SRA
        prog.push_back(r_type((k >= 8) ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3));
        store_result(3);
      end
      for (int k = 0; k < 9; k++) begin
        f3  = (k < 8) ? 3'(k) : 3'd5;
        rv  = next_rand();
        imm = (f3 == 3'd1 || f3 == 3'd5) ? {(k == 8) ? 7'h20 : 7'h00, rv[4:0]} : rv[11:0];
        prog.push_back(i_type(imm, 5'd1, f3, 5'd4, OP_IMM));
        store_result(4);
      end
      rv = next_rand();
      prog.push_back(u_type(rv[31:12], 5'd5, OP_AUIPC));
      store_result(5);
    end
    // Branches on (x1,x2), (x2,x1), (x1,x1) with x1 = -5, x2 = 3
    prog.push_back(i_type(12'hffb, 5'd0, 3'd0, 5'd1, OP_IMM));
    prog.push_back(i_type(12'h003, 5'd0, 3'd0, 5'd2, OP_IMM));
    prog.push_back(i_type(12'h000, 5'd0, 3'd0, 5'd5, OP_IMM));
    for (int c = 0; c < 8; c++) begin
      if (c != 2 && c != 3) begin
        for (int p = 0; p < 3; p++) begin
          prog.push_back(b_type(13'd8, (p == 0) ? 5'd2 : 5'd1, (p == 1) ? 5'd2 : 5'd1, 3'(c)));
          prog.push_back(i_type(12'(c * 3 + p + 1), 5'd5, 3'd0, 5'd5, OP_IMM)); // Skipped if taken
        end
      end
    end
    store_result(5);
    prog.push_back(j_type(21'd8, 5'd6));
    prog.push_back(i_type(12'h001, 5'd0, 3'd0, 5'd5, OP_IMM));
    store_result(6);
    prog.push_back(u_type(20'h0, 5'd7, OP_AUIPC));
    prog.push_back(i_type(12'd13, 5'd7, 3'd0, 5'd8, OP_JALR)); // Odd offset, lands on +12
    prog.push_back(i_type(12'h002, 5'd0, 3'd0, 5'd5, OP_IMM));
    store_result(8);
    store_result(5);
    // Sub-word stores
    set_reg(9, next_rand());
    for (int o = 0; o < 4; o++) prog.push_back(s_type(12'(32'h40 + o), 5'd9, 5'd0, 3'd0));
    for (int o = 0; o < 4; o += 2) prog.push_back(s_type(12'(32'h44 + o), 5'd9, 5'd0, 3'd1));
    // Load words, both sign states in every byte and half
    set_reg(11, 32'h80ff_7f01);
    prog.push_back(s_type(12'h050, 5'd11, 5'd0, 3'd2));
    set_reg(11, next_rand());
    prog.push_back(s_type(12'h054, 5'd11, 5'd0, 3'd2));
    for (int w = 0; w < 2; w++) begin
      foreach (kinds[n]) begin
        for (int o = 0; o < 4; o += (1 << kinds[n][1:0])) begin
          prog.push_back(i_type(12'(32'h50 + 4 * w + o), 5'd0, kinds[n], 5'd10, OP_LOAD));
          store_result(10);
        end
      end
    end
    prog.push_back(i_type(12'h050, 5'd0, 3'd2, 5'd0, OP_LOAD)); // x0 stays zero
    prog.push_back(i_type(12'h123, 5'd0, 3'd0, 5'd0, OP_IMM));
    store_result(0);
    prog.push_back(32'h0ff0_028f); // FENCE with rd field x5
    store_result(5);
    prog.push_back(32'h0000_0073); // ECALL
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
      $display("Result: FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  initial begin
    rst    = 1'b1;
    ref_pc = `RV_RESET_PC;
    for (int i = 0; i < `RV_NUM_REGS; i++) ref_regs[i] = '0;
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i]     = data_fill(32'(i * 4));
      ref_dmem[i] = data_fill(32'(i * 4));
    end
    build_program();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : 32'h0000_0013; // NOP past the end
    end
    prog_len = prog.size();
    // Reset has to mask a store and then an ECALL fetched from address 0
    imem[0] = s_type(12'h000, 5'd0, 5'd0, 3'd2);
    repeat (RST_CYCLES / 2) @(posedge clk);
    #1 imem[0] = 32'h0000_0073;
    repeat (RST_CYCLES - RST_CYCLES / 2) @(posedge clk);
    #1;
    imem[0] = prog[0];
    rst     = 1'b0;
  end

  // Compare at the falling edge, where all combinational outputs have settled
  initial begin
    done = 1'b0;
    @(posedge clk);
    @(negedge clk);
    while (rst) begin
      check("dmem_be", dmem_be, '0);
      check("halt", halt, 1'b0);
      @(negedge clk);
    end
    while (!done) begin
      check("imem_addr", imem_addr, ref_pc);
      ref_step(imem[ref_pc[10:2]]);
      check("dmem_be", dmem_be, exp_be);
      check("halt", halt, exp_halt);
      if (exp_be != '0) begin
        check("dmem_addr", dmem_addr, exp_addr);
        check("dmem_wdata", dmem_wdata, exp_wdata);
      end
      done = exp_halt;
      if (!done) @(negedge clk);
    end
    $display("Result: PASSED");
    $finish;
  end

  // Four cycles per instruction is ample for a single-cycle core
  initial begin
    wait (prog_len != 0);
    #((RST_CYCLES + prog_len * 4) * CLK_PERIOD);
    $display("Watchdog expired before the core reached halt");
    $display("Result: FAILED");
    $fatal(1, "timeout");
  end

endmodule
